// ==== verilog/ppu_data_pkg.sv ====
// PPU tile geometry
// Row count, spike width and the plain vector types that carry spike data
// between the host port, tile storage and the match logic

`default_nettype none

package ppu_data_pkg;

  // ==========================================================================
  // Tile geometry
  // ==========================================================================
  localparam int ROWS   = 16;                 // Rows held in one tile
  localparam int SPIKES = 16;                 // Spike bits per row

  // ==========================================================================
  // Data types
  // ==========================================================================
  typedef logic [$clog2(ROWS)-1:0]     row_id_t;     // Row index
  typedef logic [SPIKES-1:0]           spike_pat_t;  // One row's spike pattern
  typedef logic [$clog2(SPIKES+1)-1:0] popcnt_t;     // Ones in a pattern, 0..SPIKES
  typedef logic [ROWS-1:0]             row_mask_t;   // One flag per row

  // Host write into tile storage
  typedef struct packed {
    row_id_t    addr;
    spike_pat_t pattern;
  } tile_write_t;

endpackage

`default_nettype wire

// ==== verilog/ppu_flow_pkg.sv ====
// PPU pipeline flow types
// Records handed between the sequencer, detector, selector and dispatcher,
// plus the tile sequencer FSM encoding

`default_nettype none

package ppu_flow_pkg;
  import ppu_data_pkg::*;

  // Row query from the sequencer
  typedef struct packed {
    row_id_t row_id;
    logic    last;                            // Final row of the tile
  } row_query_t;

  // Subset matches for one row
  typedef struct packed {
    row_id_t   row_id;
    logic      last;
    row_mask_t subset_mask;                   // Non-empty subsets, self excluded
  } match_t;

  // Task toward the compute core
  typedef struct packed {
    row_id_t    row_id;
    row_id_t    prefix_id;                    // Equals row_id when no prefix
    spike_pat_t residual;
    logic       last;
  } task_t;

  // Tile sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,                                 // Host may write rows
    SEQ_ISSUE,                                // Walking rows 0..ROWS-1
    SEQ_DRAIN                                 // Waiting on the final task
  } seq_state_t;

endpackage

`default_nettype wire

// ==== verilog/tile_memory.sv ====
// Tile memory
// Register file of row spike patterns with a popcount kept beside each row.
// The count is derived from the written pattern in the same cycle, so both
// views change together. All rows are read out in parallel.

`timescale 1ns/1ps
`default_nettype none

module tile_memory
  import ppu_data_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_en,      // Accepted host write
  input  tile_write_t             wr,
  output spike_pat_t [ROWS-1:0]   patterns,
  output popcnt_t    [ROWS-1:0]   popcounts
);

  // ==========================================================================
  // Popcount of a write pattern
  // ==========================================================================
  function automatic popcnt_t count_ones(input spike_pat_t pat);
    popcnt_t n;
    n = '0;
    for (int b = 0; b < SPIKES; b++) begin
      n = n + popcnt_t'(pat[b]);              // Add one per set spike
    end
    return n;
  endfunction

  popcnt_t wr_count;                          // Count of the incoming pattern

  assign wr_count = count_ones(wr.pattern);

  // ==========================================================================
  // Storage
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      patterns  <= '0;                        // Empty tile after reset
      popcounts <= '0;
    end else if (wr_en) begin
      patterns[wr.addr]  <= wr.pattern;
      popcounts[wr.addr] <= wr_count;         // Visible next cycle with pattern
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tile_sequencer.sv ====
// Tile sequencer
// Idle / issue / drain FSM for one tile. Host writes pass only while idle.
// On a start it walks rows 0..ROWS-1, one query per accepted handshake,
// then waits for the dispatcher to report the final task taken.

`timescale 1ns/1ps
`default_nettype none

module tile_sequencer
  import ppu_data_pkg::*;
  import ppu_flow_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tile_start,              // One-cycle pulse
  input  logic       tile_wr_valid,
  output logic       tile_wr_ready,
  output logic       mem_wr_en,
  output row_query_t query,
  output logic       query_valid,
  input  logic       query_ready,
  input  logic       tile_done,               // Final task handed off
  output logic       busy
);

  seq_state_t state;
  row_id_t    row_cnt;                        // Next row to issue

  // ==========================================================================
  // Control FSM
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= SEQ_IDLE;
      row_cnt <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (tile_start) begin               // Start ignored outside idle
            state   <= SEQ_ISSUE;
            row_cnt <= '0;
          end
        end
        SEQ_ISSUE: begin
          if (query_valid && query_ready) begin
            row_cnt <= row_cnt + 1'b1;
            if (query.last) state <= SEQ_DRAIN;
          end
        end
        SEQ_DRAIN: if (tile_done) state <= SEQ_IDLE;
        default:   state <= SEQ_IDLE;
      endcase
    end
  end

  // Host write gate
  assign tile_wr_ready = (state == SEQ_IDLE);
  assign mem_wr_en     = tile_wr_valid && tile_wr_ready;

  // Query toward the detector
  assign query_valid  = (state == SEQ_ISSUE);
  assign query.row_id = row_cnt;
  assign query.last   = (row_cnt == row_id_t'(ROWS-1));

  // Busy drops in the same cycle as the done pulse
  assign busy = (state == SEQ_ISSUE) || ((state == SEQ_DRAIN) && !tile_done);

endmodule

`default_nettype wire

// ==== verilog/subset_detector.sv ====
// Subset detector
// Compares one queried row against every stored row in parallel and flags
// each other row that is non-empty and has no spike outside the query.
// The flag vector is registered together with the row id and last flag.

`timescale 1ns/1ps
`default_nettype none

module subset_detector
  import ppu_data_pkg::*;
  import ppu_flow_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  row_query_t            query,
  input  logic                  query_valid,
  output logic                  query_ready,
  input  spike_pat_t [ROWS-1:0] patterns,
  input  popcnt_t    [ROWS-1:0] popcounts,
  output match_t                match,
  output logic                  match_valid,
  input  logic                  match_ready
);

  spike_pat_t q_pat;                          // Pattern of the queried row
  row_mask_t  hit;

  // ==========================================================================
  // Parallel match
  // ==========================================================================
  always_comb begin
    q_pat = patterns[query.row_id];
    for (int r = 0; r < ROWS; r++) begin
      hit[r] = (popcounts[r] != '0)                  // Skip empty rows
            && ((patterns[r] & ~q_pat) == '0)        // Nothing outside query
            && (query.row_id != row_id_t'(r));       // Not itself
    end
  end

  assign query_ready = !match_valid || match_ready;  // Empty or draining

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      match_valid <= 1'b0;
    end else if (query_valid && query_ready) begin
      match_valid <= 1'b1;
    end else if (match_ready) begin
      match_valid <= 1'b0;
    end
  end

  // Payload, held until taken
  always_ff @(posedge clk) begin
    if (query_valid && query_ready) begin
      match.row_id      <= query.row_id;
      match.last        <= query.last;
      match.subset_mask <= hit;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/prefix_selector.sv ====
// Prefix selector
// Picks the best prefix among a row's subset matches: highest popcount wins
// and the lowest index breaks a tie. Without a match the row is its own
// prefix. The registered task carries the residual spike pattern.

`timescale 1ns/1ps
`default_nettype none

module prefix_selector
  import ppu_data_pkg::*;
  import ppu_flow_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  match_t                match,
  input  logic                  match_valid,
  output logic                  match_ready,
  input  spike_pat_t [ROWS-1:0] patterns,
  input  popcnt_t    [ROWS-1:0] popcounts,
  output task_t                 sel_task,
  output logic                  sel_valid,
  input  logic                  sel_ready
);

  row_id_t    best_id;
  popcnt_t    best_pc;
  logic       found;                          // At least one match seen
  spike_pat_t row_pat;
  spike_pat_t residual;

  // ==========================================================================
  // Best prefix scan
  // ==========================================================================
  always_comb begin
    best_id = match.row_id;                   // Self-reference fallback
    best_pc = '0;
    found   = 1'b0;
    // Ascending scan with strict compare keeps the lowest index on a tie
    for (int i = 0; i < ROWS; i++) begin
      if (match.subset_mask[i] && (!found || (popcounts[i] > best_pc))) begin
        best_id = row_id_t'(i);
        best_pc = popcounts[i];
        found   = 1'b1;
      end
    end
  end

  assign row_pat  = patterns[match.row_id];
  assign residual = found ? (row_pat ^ patterns[best_id]) : row_pat;  // Full if no prefix

  // ==========================================================================
  // Output register
  // ==========================================================================
  assign match_ready = !sel_valid || sel_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel_valid <= 1'b0;
    end else if (match_valid && match_ready) begin
      sel_valid <= 1'b1;
    end else if (sel_ready) begin
      sel_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (match_valid && match_ready) begin
      sel_task.row_id    <= match.row_id;
      sel_task.prefix_id <= best_id;
      sel_task.residual  <= residual;
      sel_task.last      <= match.last;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/task_dispatcher.sv ====
// Task dispatcher
// Circular task queue toward the compute core, head presented directly.
// Pulses tile_done the cycle after the task flagged last is taken.

`timescale 1ns/1ps
`default_nettype none

module task_dispatcher
  import ppu_flow_pkg::*;
#(
  parameter int TASK_FIFO_DEPTH = 2           // Queue entries, 2 or more
) (
  input  logic  clk,
  input  logic  rst_n,
  input  task_t sel_task,
  input  logic  sel_valid,
  output logic  sel_ready,
  output task_t task_data,
  output logic  task_valid,
  input  logic  task_ready,
  output logic  tile_done
);

  localparam int PTR_W = $clog2(TASK_FIFO_DEPTH);
  localparam int CNT_W = $clog2(TASK_FIFO_DEPTH + 1);

  task_t             queue [TASK_FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;                   // Occupancy
  logic              push;
  logic              pop;

  // Wrap for any depth, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(TASK_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign task_valid = (count != '0);
  assign task_data  = queue[rd_ptr];          // Head entry
  assign pop        = task_valid && task_ready;
  assign sel_ready  = (count != CNT_W'(TASK_FIFO_DEPTH)) || task_ready;  // Full but popping
  assign push       = sel_valid && sel_ready;

  // ==========================================================================
  // Queue control
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      tile_done <= 1'b0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop)  rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;              // Idle or push with pop
      endcase
      tile_done <= pop && task_data.last;     // One-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (push) queue[wr_ptr] <= sel_task;
  end

endmodule

`default_nettype wire

// ==== verilog/ppu_top.sv ====
// PPU front end top level
// Host row loading, tile sequencing, subset detection, prefix pruning and
// task dispatch for one tile of spike rows

`timescale 1ns/1ps
`default_nettype none

module ppu_top
  import ppu_data_pkg::*;
  import ppu_flow_pkg::*;
#(
  parameter int TASK_FIFO_DEPTH = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        tile_wr_valid,          // Host row write
  output logic        tile_wr_ready,
  input  tile_write_t tile_wr,
  input  logic        tile_start,             // Tile control
  output logic        busy,
  output logic        tile_done,
  output logic        task_valid,             // Toward the compute core
  input  logic        task_ready,
  output task_t       task_data
);

  // ==========================================================================
  // Internal wiring
  // ==========================================================================
  logic                  mem_wr_en;
  spike_pat_t [ROWS-1:0] patterns;
  popcnt_t    [ROWS-1:0] popcounts;
  row_query_t            query;
  logic                  query_valid, query_ready;
  match_t                match;
  logic                  match_valid, match_ready;
  task_t                 sel_task;
  logic                  sel_valid, sel_ready;

  tile_memory i_tile_memory (
    .clk, .rst_n, .wr_en(mem_wr_en), .wr(tile_wr), .patterns, .popcounts
  );

  tile_sequencer i_tile_sequencer (
    .clk, .rst_n, .tile_start, .tile_wr_valid, .tile_wr_ready, .mem_wr_en,
    .query, .query_valid, .query_ready, .tile_done, .busy
  );

  subset_detector i_subset_detector (
    .clk, .rst_n, .query, .query_valid, .query_ready, .patterns, .popcounts,
    .match, .match_valid, .match_ready
  );

  prefix_selector i_prefix_selector (
    .clk, .rst_n, .match, .match_valid, .match_ready, .patterns, .popcounts,
    .sel_task, .sel_valid, .sel_ready
  );

  task_dispatcher #(
    .TASK_FIFO_DEPTH(TASK_FIFO_DEPTH)
  ) i_task_dispatcher (
    .clk, .rst_n, .sel_task, .sel_valid, .sel_ready,
    .task_data, .task_valid, .task_ready, .tile_done
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset
// 10 ns clock, active-low reset held for a fixed number of rising edges

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                    // 10 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;                            // Released on an edge
  end

endmodule

`default_nettype wire

// ==== testbench/tb_ppu.sv ====
// PPU front end testbench
// Loads random sparse tiles, runs them through ppu_top and checks every task
// against a reference model of the prefix rule, plus timing, stalls,
// busy and done behavior, and host writes blocked during a tile

`timescale 1ns/1ps
`default_nettype none

module tb_ppu
  import ppu_data_pkg::*;
  import ppu_flow_pkg::*;
;

  localparam int NUM_TILES       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TILES * ROWS * 20 + 1000;  // Tiles plus load margin

  logic        clk;
  logic        rst_n;
  logic        tile_wr_valid;
  logic        tile_wr_ready;
  tile_write_t tile_wr;
  logic        tile_start;
  logic        busy;
  logic        tile_done;
  logic        task_valid;
  logic        task_ready;
  task_t       task_out;

  spike_pat_t  model_pat [ROWS];              // Mirror of accepted writes
  logic [15:0] lfsr = 16'd44;
  int          test_errors = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;
  int          self_refs;                     // Tasks with prefix_id == row_id

  tb_clock_gen i_clock_gen (.clk, .rst_n);

  ppu_top #(.TASK_FIFO_DEPTH(2)) i_dut (      // Port order of ppu_top
    clk, rst_n, tile_wr_valid, tile_wr_ready, tile_wr, tile_start,
    busy, tile_done, task_valid, task_ready, task_out
  );

  // ==========================================================================
  // Helpers
  // ==========================================================================
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Prefix rule: largest non-empty subset, lowest index on a tie
  function automatic task_t expected_task(input int r);
    task_t t;
    int    best;
    int    best_pc;
    best    = r;
    best_pc = 0;
    for (int j = 0; j < ROWS; j++) begin
      if (j != r && model_pat[j] != '0 && (model_pat[j] & ~model_pat[r]) == '0
          && $countones(model_pat[j]) > best_pc) begin
        best    = j;                          // Strict compare keeps lowest index
        best_pc = $countones(model_pat[j]);
      end
    end
    t.row_id    = row_id_t'(r);
    t.prefix_id = row_id_t'(best);
    t.residual  = (best == r) ? model_pat[r] : (model_pat[r] ^ model_pat[best]);
    t.last      = (r == ROWS - 1);
    return t;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) pass_count++;
    else fail_count++;
    $display("%-40s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "fail", test_errors);
    test_errors = 0;
  endtask

  task automatic load_row(input int addr, input spike_pat_t pat);
    @(posedge clk);
    assert (tile_wr_ready) else report_mismatch("host write refused while idle");
    tile_wr_valid <= 1'b1;
    tile_wr       <= {row_id_t'(addr), pat};
    model_pat[addr] = pat;                    // Taken on the next edge, idle
  endtask

  // Sparse rows, AND of two draws, some forced empty
  task automatic load_random_rows(input int count);
    spike_pat_t pat;
    int         addr;
    for (int i = 0; i < count; i++) begin
      addr = (count == ROWS) ? i : int'(draw_bits(4));
      pat  = spike_pat_t'(draw_bits(SPIKES)) & spike_pat_t'(draw_bits(SPIKES));
      if (draw_bits(3) == 0) pat = '0;
      load_row(addr, pat);
    end
  endtask

  // ==========================================================================
  // One tile: start, collect and check all tasks, done and busy
  // ==========================================================================
  task automatic run_tile(input bit random_ready, input bit poke);
    int    n;
    int    next_idx;
    int    last_hs;
    int    done_n;
    int    done_count;
    bit    held;
    task_t held_task;
    task_t exp_t;
    n = 0;
    next_idx = 0;
    last_hs = -1;
    done_n = 0;
    done_count = 0;
    held = 1'b0;
    self_refs = 0;
    @(posedge clk);
    tile_wr_valid <= 1'b0;
    tile_start    <= 1'b1;
    task_ready    <= random_ready ? (draw_bits(1) != 0) : 1'b1;
    while (done_count == 0 || n < done_n + 3) begin
      @(posedge clk);
      n++;
      if (held) begin                         // Stalled head must hold
        assert (task_valid && task_out == held_task)
          else report_mismatch("task changed while stalled");
      end
      if (task_valid && task_ready) begin
        exp_t = expected_task(next_idx);
        assert (next_idx < ROWS && task_out == exp_t)
          else report_mismatch($sformatf("task %0d got %h expected %h",
                                         next_idx, task_out, exp_t));
        if (!random_ready) begin
          assert (n == 5 + next_idx)
            else report_mismatch($sformatf("task %0d on cycle %0d", next_idx, n));
        end
        if (task_out.prefix_id == task_out.row_id) self_refs++;
        next_idx++;
        last_hs = n;
      end
      if (tile_done) begin
        done_count++;
        done_n = n;
        assert (n == last_hs + 1 && next_idx == ROWS)
          else report_mismatch("tile_done not right after last task");
        assert (!busy) else report_mismatch("busy high on tile_done");
      end else if (done_count == 0 && n >= 2) begin
        assert (busy && !tile_wr_ready)
          else report_mismatch("busy low or writes open during tile");
      end else if (done_count != 0) begin
        assert (!busy && tile_wr_ready) else report_mismatch("not idle after tile");
      end
      held = task_valid && !task_ready;
      held_task = task_out;
      // Blocked writes and stray starts while busy
      tile_start    <= poke && busy && (draw_bits(2) == 0);
      tile_wr_valid <= poke && busy;
      tile_wr       <= tile_write_t'(draw_bits(20));
      task_ready    <= random_ready ? (draw_bits(1) != 0) : 1'b1;
    end
    assert (next_idx == ROWS && done_count == 1)
      else report_mismatch($sformatf("%0d tasks, %0d done pulses", next_idx, done_count));
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    tile_wr_valid = 1'b0;
    tile_wr       = '0;
    tile_start    = 1'b0;
    task_ready    = 1'b0;
    for (int r = 0; r < ROWS; r++) model_pat[r] = '0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    assert (!task_valid && !tile_done && !busy && tile_wr_ready)
      else report_mismatch("outputs wrong after reset");
    finish_test("1 reset values");

    load_random_rows(ROWS);
    run_tile(1'b0, 1'b0);
    finish_test("2 full tile, ready held high");

    for (int r = 0; r < ROWS; r++) begin      // Disjoint one-hot rows and empties
      load_row(r, (r % 3 == 0) ? spike_pat_t'(0) : spike_pat_t'(1) << r);
    end
    run_tile(1'b0, 1'b0);
    assert (self_refs == ROWS) else report_mismatch("row without subset got a prefix");
    finish_test("3 self-reference rows");

    load_random_rows(ROWS);
    run_tile(1'b1, 1'b0);
    finish_test("4 random back-pressure");

    run_tile(1'b0, 1'b1);                     // Writes and starts while busy
    run_tile(1'b1, 1'b0);                     // Same model must still hold
    finish_test("5 done pulse, writes blocked");

    load_random_rows(6);
    run_tile(1'b1, 1'b1);
    finish_test("6 second tile after rewrite");

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Timeout: simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/ppu_data_pkg.sv
verilog/ppu_flow_pkg.sv
verilog/tile_memory.sv
verilog/tile_sequencer.sv
verilog/subset_detector.sv
verilog/prefix_selector.sv
verilog/task_dispatcher.sv
verilog/ppu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_ppu.sv
